// File: logic/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

  // data word shared by registers, immediates, alu and apb data
  typedef logic [31:0] word_t;

  // register index x0..x31
  typedef logic [4:0] reg_addr_t;

  // instruction function fields
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // apb byte address, 4 kB window
  typedef logic [11:0] apb_addr_t;

  // rv32i major opcodes handled here
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;

  // apb address map
  // instruction word, write only
  localparam apb_addr_t addr_instr    = 12'h000;
  // last result, read only
  localparam apb_addr_t addr_result   = 12'h004;
  // x0..x31 at base + 4n
  localparam apb_addr_t addr_reg_base = 12'h080;

  // execute sequencer states
  typedef enum logic {
    seq_idle,
    seq_exec
  } seq_state_t;

endpackage

`default_nettype wire

// File: logic/rv_dec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_dec_if import rv_exec_pkg::*; ();

  // register addresses
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;

  // operand and function fields
  word_t     imm;
  funct3_t   funct3;
  funct7_t   funct7;

  // instruction class, one hot or illegal
  logic      arithmetic;
  logic      arithmetic_imm;
  logic      load;
  logic      store;
  logic      branch;
  logic      illegal;

  // decoder side
  modport producer (
    output rs1_addr, rs2_addr, rd_addr, imm, funct3, funct7,
    output arithmetic, arithmetic_imm, load, store, branch, illegal
  );

  // register file and alu side
  modport consumer (
    input rs1_addr, rs2_addr, rd_addr, imm, funct3, funct7,
    input arithmetic, arithmetic_imm, load, store, branch, illegal
  );

endinterface

`default_nettype wire

// File: logic/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_exec_pkg::*; (
  input  word_t               instr,
  rv_dec_if.producer          dec
);

  // immediate formats
  word_t   imm_i;
  word_t   imm_s;
  funct3_t funct3;
  logic    is_shift;

  // i type, sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};

  // s type, split across two fields
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

  assign funct3 = instr[14:12];

  // slli / srli / srai carry funct7 in the immediate
  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

  always_comb begin
    // fixed field positions
    dec.rs1_addr = instr[19:15];
    dec.rs2_addr = instr[24:20];
    dec.rd_addr  = instr[11:7];
    dec.funct3   = funct3;

    // defaults
    dec.imm            = '0;
    dec.funct7         = '0;
    dec.arithmetic     = 1'b0;
    dec.arithmetic_imm = 1'b0;
    dec.load           = 1'b0;
    dec.store          = 1'b0;
    dec.branch         = 1'b0;
    dec.illegal        = 1'b0;

    case (instr[6:0])
      opc_op: begin
        // register-register, funct7 used as is
        dec.arithmetic = 1'b1;
        dec.funct7     = instr[31:25];
      end
      opc_op_imm: begin
        dec.arithmetic_imm = 1'b1;
        dec.imm            = imm_i;
        // only shifts keep bit 30, so addi etc. still select add
        if (is_shift) begin
          dec.funct7 = {1'b0, instr[30], 5'b00000};
        end
      end
      opc_load: begin
        // address = rs1 + imm_i
        dec.load = 1'b1;
        dec.imm  = imm_i;
      end
      opc_store: begin
        // address = rs1 + imm_s
        dec.store = 1'b1;
        dec.imm   = imm_s;
      end
      opc_branch: begin
        // compare only, rs1 against rs2
        dec.branch = 1'b1;
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_exec_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  rv_dec_if.consumer          dec,
  input  logic                we,
  input  reg_addr_t           waddr,
  input  word_t               wdata,
  input  reg_addr_t           raddr,
  output word_t               rs1_data,
  output word_t               rs2_data,
  output word_t               rdata
);

  // x1..x31, x0 has no storage
  word_t regs [1:31];

  // single write port, x0 writes dropped
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // alu read ports
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (dec.rs1_addr != 5'd0) begin
      rs1_data = regs[dec.rs1_addr];
    end
    if (dec.rs2_addr != 5'd0) begin
      rs2_data = regs[dec.rs2_addr];
    end
  end

  // host read port
  always_comb begin
    rdata = '0;
    if (raddr != 5'd0) begin
      rdata = regs[raddr];
    end
  end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_exec_pkg::*; (
  input  word_t               rs1_data,
  input  word_t               rs2_data,
  rv_dec_if.consumer          dec,
  output word_t               alu_out
);

  // second operand
  word_t op2;

  // immediate for op-imm, load and store; rs2 for op and branch
  assign op2 = (dec.arithmetic_imm || dec.store || dec.load) ? dec.imm : rs2_data;

  always_comb begin
    if (dec.load || dec.store) begin
      // effective address
      alu_out = rs1_data + op2;
    end else if (dec.arithmetic || dec.arithmetic_imm) begin
      case ({dec.funct7, dec.funct3})
        // add / addi
        10'b0000000_000: alu_out = rs1_data + op2;
        // sub, register form only
        10'b0100000_000: alu_out = rs1_data - op2;
        // or / ori
        10'b0000000_110: alu_out = rs1_data | op2;
        // and / andi
        10'b0000000_111: alu_out = rs1_data & op2;
        // xor / xori
        10'b0000000_100: alu_out = rs1_data ^ op2;
        // sll / slli, low 5 bits of shamt
        10'b0000000_001: alu_out = rs1_data << op2[4:0];
        // slt / slti
        10'b0000000_010: begin
          alu_out = ($signed(rs1_data) < $signed(op2)) ? 32'd1 : 32'd0;
        end
        // sltu / sltiu
        10'b0000000_011: alu_out = (rs1_data < op2) ? 32'd1 : 32'd0;
        // srl / srli
        10'b0000000_101: alu_out = rs1_data >> op2[4:0];
        // sra / srai, needs arithmetic shift
        10'b0100000_101: alu_out = word_t'($signed(rs1_data) >>> op2[4:0]);
        // unsupported combination
        default:         alu_out = 32'd0;
      endcase
    end else if (dec.branch) begin
      // one bit compare result, zero extended
      case (dec.funct3)
        // beq
        3'b000:  alu_out = {31'b0, (rs1_data == op2)};
        // bne
        3'b001:  alu_out = {31'b0, (rs1_data != op2)};
        // blt
        3'b100:  alu_out = {31'b0, ($signed(rs1_data) < $signed(op2))};
        // bge
        3'b101:  alu_out = {31'b0, ($signed(rs1_data) >= $signed(op2))};
        // bltu
        3'b110:  alu_out = {31'b0, (rs1_data < op2)};
        // bgeu
        3'b111:  alu_out = {31'b0, (rs1_data >= op2)};
        // codes 2 and 3 undefined
        default: alu_out = 32'd0;
      endcase
    end else begin
      // illegal, nothing to compute
      alu_out = 32'd0;
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_exec_apb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_apb import rv_exec_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  apb_addr_t           paddr,
  input  word_t               pwdata,
  output word_t               prdata,
  output logic                pready,
  output logic                pslverr,
  output word_t               instr,
  input  logic                dec_illegal,
  input  logic                dec_arith,
  input  reg_addr_t           rd_addr,
  input  word_t               alu_out,
  output logic                rf_we,
  output reg_addr_t           rf_waddr,
  output word_t               rf_wdata,
  output reg_addr_t           rf_raddr,
  input  word_t               rf_rdata
);

  seq_state_t state;
  word_t      result_q;

  logic       access;
  logic       is_instr;
  logic       is_result;
  logic       is_reg;
  logic       instr_wr;
  logic       bad_access;
  logic       exec;
  reg_addr_t  host_reg;

  // access phase of a transfer
  assign access = psel && penable;

  // address map decode
  assign is_instr  = (paddr == addr_instr);
  assign is_result = (paddr == addr_result);
  // word aligned within 0x080..0x0fc
  assign is_reg    = (paddr[11:7] == addr_reg_base[11:7]) && (paddr[1:0] == 2'b00);
  assign host_reg  = paddr[6:2];

  assign instr_wr = pwrite && is_instr;

  // unmapped address or read of instr or write of result
  assign bad_access = !(is_reg || (is_result && !pwrite) || instr_wr);

  // second access cycle of an instruction write
  assign exec = (state == seq_exec);

  // one wait state for instruction writes only
  assign pready = access && (!instr_wr || exec);

  // error response during the access phase
  assign pslverr = access && (exec ? dec_illegal : bad_access);

  // read data valid in the first access cycle
  always_comb begin
    prdata = '0;
    if (!pwrite && is_result) begin
      prdata = result_q;
    end else if (!pwrite && is_reg) begin
      prdata = rf_rdata;
    end
  end

  assign rf_raddr = host_reg;

  // host write or writeback on the shared port
  assign rf_we    = (access && pwrite && is_reg) || (exec && dec_arith && !dec_illegal);
  assign rf_waddr = exec ? rd_addr : host_reg;
  assign rf_wdata = exec ? alu_out : pwdata;

  // execute sequencer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= seq_idle;
    end else begin
      case (state)
        seq_idle: begin
          // first access cycle of an instruction write
          if (access && instr_wr) begin
            state <= seq_exec;
          end
        end
        seq_exec: begin
          // transfer completes here
          state <= seq_idle;
        end
        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

  // instruction register loaded on entry to exec
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr <= '0;
    end else if (!exec && access && instr_wr) begin
      instr <= pwdata;
    end
  end

  // result register kept on an illegal opcode
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_q <= '0;
    end else if (exec && !dec_illegal) begin
      result_q <= alu_out;
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top import rv_exec_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  apb_addr_t           paddr,
  input  word_t               pwdata,
  output word_t               prdata,
  output logic                pready,
  output logic                pslverr
);

  // decoded instruction bundle
  rv_dec_if dec ();

  word_t     instr;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_out;
  logic      dec_arith;

  // register file write and host read port
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  reg_addr_t rf_raddr;
  word_t     rf_rdata;

  // either arithmetic form writes rd
  assign dec_arith = dec.arithmetic || dec.arithmetic_imm;

  rv_decoder i_decoder (
    .instr    (instr),
    .dec      (dec.producer)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .dec      (dec.consumer),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata),
    .raddr    (rf_raddr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rdata    (rf_rdata)
  );

  alu i_alu (
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec.consumer),
    .alu_out  (alu_out)
  );

  // apb slave and sequencer in place of a pipeline
  rv_exec_apb i_apb (
    .clk         (clk),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .instr       (instr),
    .dec_illegal (dec.illegal),
    .dec_arith   (dec_arith),
    .rd_addr     (dec.rd_addr),
    .alu_out     (alu_out),
    .rf_we       (rf_we),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .rf_raddr    (rf_raddr),
    .rf_rdata    (rf_rdata)
  );

endmodule

`default_nettype wire

// File: verification/rv_exec_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_asserts import rv_exec_pkg::*; (
  input logic       clk,
  input logic       arst_n,
  input logic       psel,
  input logic       penable,
  input logic       pwrite,
  input apb_addr_t  paddr,
  input word_t      prdata,
  input logic       pready,
  input logic       pslverr,
  input seq_state_t state
);

  // failed assertion count
  int fails = 0;

  // error response only on a completing transfer
  a_err_with_ready: assert property (
    @(posedge clk) disable iff (!arst_n) pslverr |-> pready
  ) else begin
    $error("pslverr high while pready low");
    fails++;
  end

  // instruction write, one wait state then done
  a_instr_one_wait: assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == seq_idle && psel && penable && pwrite && paddr == addr_instr)
      |-> !pready ##1 pready
  ) else begin
    $error("instruction write did not complete after one wait state");
    fails++;
  end

  // x0 reads back as zero
  a_x0_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
    (psel && penable && !pwrite && paddr == addr_reg_base) |-> (prdata == '0)
  ) else begin
    $error("read of x0 returned a nonzero value");
    fails++;
  end

endmodule

bind rv_exec_apb rv_exec_asserts i_asserts (
  .clk     (clk),
  .arst_n  (arst_n),
  .psel    (psel),
  .penable (penable),
  .pwrite  (pwrite),
  .paddr   (paddr),
  .prdata  (prdata),
  .pready  (pready),
  .pslverr (pslverr),
  .state   (state)
);

`default_nettype wire

// File: verification/tb_rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec import rv_exec_pkg::*; ();

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        pslverr;

  // expected contents of x0..x31
  word_t       model [0:31];
  integer      seed;
  int          errors;
  word_t       a;
  word_t       b;
  word_t       rdat;
  word_t       last;
  logic [11:0] imm12;

  rv_exec_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic expect_eq(input string name, input word_t exp, input word_t got);
    assert (got === exp) else begin
      $display("ERR %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  // one transfer starting and ending just after a rising edge
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                          input logic exp_err, output word_t rd);
    int cycles;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    cycles  = 0;
    // pready settles well before the falling edge
    @(negedge clk);
    while (!pready && cycles < 8) begin
      cycles++;
      @(negedge clk);
    end
    if (!pready) begin
      $display("timeout, pready never rose for the transfer at address %h", addr);
      $display("Test failed");
      $finish;
    end else begin
      rd = prdata;
      expect_eq("pslverr", {31'b0, exp_err}, {31'b0, pslverr});
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic reg_write(input reg_addr_t n, input word_t v);
    word_t unused;
    apb_xfer(1'b1, addr_reg_base + {5'b0, n, 2'b00}, v, 1'b0, unused);
    if (n != 5'd0) begin
      model[n] = v;
    end
  endtask

  task automatic reg_check(input reg_addr_t n);
    word_t got;
    apb_xfer(1'b0, addr_reg_base + {5'b0, n, 2'b00}, '0, 1'b0, got);
    expect_eq($sformatf("prdata x%0d", n), model[n], got);
  endtask

  task automatic check_all_regs();
    for (int n = 0; n < 32; n++) begin
      reg_check(reg_addr_t'(n));
    end
  endtask

  // instruction write then RESULT read back
  task automatic run_instr(input word_t ins, input word_t exp);
    word_t got;
    apb_xfer(1'b1, addr_instr, ins, 1'b0, got);
    apb_xfer(1'b0, addr_result, '0, 1'b0, got);
    expect_eq("result", exp, got);
    last = exp;
  endtask

  // signed less-than by sign bits first
  function automatic logic lt_signed(input word_t x, input word_t y);
    return (x[31] != y[31]) ? x[31] : (x < y);
  endfunction

  function automatic word_t arith_ref(input logic alt, input funct3_t f3,
                                      input word_t x, input word_t y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return {31'b0, lt_signed(x, y)};
      3'd3: return {31'b0, x < y};
      3'd4: return x ^ y;
      // sra as logical shift plus sign fill
      3'd5: return (x >> y[4:0]) | ((alt && x[31]) ? ~(32'hffffffff >> y[4:0]) : 32'd0);
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic word_t branch_ref(input funct3_t f3, input word_t x, input word_t y);
    case (f3)
      3'd0: return {31'b0, x == y};
      3'd1: return {31'b0, x != y};
      3'd4: return {31'b0, lt_signed(x, y)};
      3'd5: return {31'b0, !lt_signed(x, y)};
      3'd6: return {31'b0, x < y};
      3'd7: return {31'b0, x >= y};
      default: return 32'd0;
    endcase
  endfunction

  // op-imm on x1 with srai when imm bit 10 is set
  task automatic imm_op(input funct3_t f3, input logic [11:0] imm, input reg_addr_t rd);
    word_t exp;
    exp = arith_ref((f3 == 3'd5) && imm[10], f3, model[1], {{20{imm[11]}}, imm});
    run_instr({imm, 5'd1, f3, rd, opc_op_imm}, exp);
    model[rd] = exp;
    reg_check(rd);
  endtask

  initial begin
    seed    = 32'hbbaf4fbe;
    errors  = 0;
    last    = '0;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // reset state and x0 ignoring writes
    apb_xfer(1'b0, addr_result, '0, 1'b0, rdat);
    expect_eq("result", 32'd0, rdat);
    for (int n = 0; n < 32; n += 5) begin
      reg_check(reg_addr_t'(n));
    end
    reg_write(5'd0, $random(seed));
    reg_check(5'd0);

    // register-register with opposite signs in the first two rounds
    for (int r = 0; r < 4; r++) begin
      a = $random(seed);
      b = $random(seed);
      if (r < 2) begin
        a[31] = (r == 0);
        b[31] = (r == 1);
      end
      reg_write(5'd1, a);
      reg_write(5'd2, b);
      for (int k = 0; k < 10; k++) begin
        // k 8 is sub and k 9 is sra
        run_instr({1'b0, k >= 8, 5'b0, 5'd2, 5'd1, (k == 9) ? 3'd5 : funct3_t'(k),
                   reg_addr_t'(3 + k), opc_op},
                  arith_ref(k >= 8, (k == 9) ? 3'd5 : funct3_t'(k), a, b));
        model[3 + k] = last;
        reg_check(reg_addr_t'(3 + k));
      end
    end

    // immediates on a negative x1 so srai shows sign fill
    a = $random(seed);
    a[31] = 1'b1;
    reg_write(5'd1, a);
    imm_op(3'd0, 12'hfff, 5'd12);
    imm_op(3'd0, 12'h800, 5'd13);
    imm_op(3'd0, 12'h7ff, 5'd14);
    imm_op(3'd2, 12'hf00, 5'd15);
    imm_op(3'd3, 12'hfff, 5'd16);
    imm_op(3'd7, 12'($random(seed)), 5'd17);
    imm_op(3'd6, 12'($random(seed)), 5'd18);
    imm_op(3'd4, 12'($random(seed)), 5'd19);
    imm_op(3'd1, 12'h007, 5'd20);
    imm_op(3'd5, 12'h00d, 5'd21);
    imm_op(3'd5, 12'h409, 5'd22);

    // load and store addresses
    for (int r = 0; r < 3; r++) begin
      imm12 = 12'($random(seed));
      run_instr({imm12, 5'd1, 3'd2, 5'd10, opc_load}, model[1] + {{20{imm12[11]}}, imm12});
      imm12 = 12'($random(seed));
      run_instr({imm12[11:5], 5'd2, 5'd1, 3'd2, imm12[4:0], opc_store},
                model[1] + {{20{imm12[11]}}, imm12});
    end
    check_all_regs();

    // branch compares on equal, mixed sign and random pairs
    for (int p = 0; p < 4; p++) begin
      a = $random(seed);
      b = (p == 0) ? a : $random(seed);
      if (p == 1 || p == 2) begin
        a[31] = (p == 2);
        b[31] = (p == 1);
      end
      reg_write(5'd1, a);
      reg_write(5'd2, b);
      for (int f = 0; f < 8; f++) begin
        run_instr({7'b0, 5'd2, 5'd1, funct3_t'(f), 5'd11, opc_branch},
                  branch_ref(funct3_t'(f), a, b));
      end
    end
    check_all_regs();

    // error responses change nothing
    apb_xfer(1'b1, addr_instr, {12'h001, 5'd1, 3'd0, 5'd3, 7'h7f}, 1'b1, rdat);
    apb_xfer(1'b0, 12'h008, '0, 1'b1, rdat);
    apb_xfer(1'b0, addr_instr, '0, 1'b1, rdat);
    apb_xfer(1'b1, addr_result, 32'hdeadbeef, 1'b1, rdat);
    apb_xfer(1'b0, addr_result, '0, 1'b0, rdat);
    expect_eq("result", last, rdat);
    check_all_regs();

    errors += i_dut.i_apb.i_asserts.fails;
    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
logic/rv_exec_pkg.sv
logic/rv_dec_if.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/alu.sv
logic/rv_exec_apb.sv
logic/rv_exec_top.sv
verification/rv_exec_asserts.sv
verification/tb_rv_exec.sv

// File: Bender.yml
package:
  name: rv_exec

sources:
  - target: any(rtl, test)
    files:
      - logic/rv_exec_pkg.sv
      - logic/rv_dec_if.sv
      - logic/rv_decoder.sv
      - logic/rv_regfile.sv
      - logic/alu.sv
      - logic/rv_exec_apb.sv
      - logic/rv_exec_top.sv
  - target: test
    files:
      - verification/rv_exec_asserts.sv
      - verification/tb_rv_exec.sv
